// File: design/outlier_pkg.sv
`default_nettype none

package outlier_pkg;

    // vector geometry
    localparam int CHANNELS    = 8;
    localparam int SAMPLE_BITS = 16;
    localparam int CODE_BITS   = 3;

    // priority pick depth, also the largest limit that still has effect
    localparam int MAX_OUTLIERS = 3;
    localparam int LIMIT_BITS   = 2;

    // config register map
    localparam logic CFG_ADDR_THRESHOLD = 1'b0;
    localparam logic CFG_ADDR_LIMIT     = 1'b1;

    // values after reset
    localparam logic [CODE_BITS-1:0]  THRESHOLD_RESET = 3'd6;
    localparam logic [LIMIT_BITS-1:0] LIMIT_RESET     = 2'd2;

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // channel 0 in the lowest slice
    typedef sample_t [CHANNELS-1:0] sample_vec_t;
    typedef logic [CHANNELS-1:0][CODE_BITS-1:0] code_vec_t;
    typedef logic [CHANNELS-1:0] channel_mask_t;

    typedef struct packed {
        logic [CODE_BITS-1:0]  threshold;
        logic [LIMIT_BITS-1:0] outlier_limit;
    } split_cfg_t;

    // outliers and inliers are complementary, mask marks the outlier side
    typedef struct packed {
        sample_vec_t   outliers;
        sample_vec_t   inliers;
        channel_mask_t mask;
    } split_result_t;

endpackage

`default_nettype wire

// File: design/magnitude_quantizer.sv
`timescale 1ns/1ns
`default_nettype none

module magnitude_quantizer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  outlier_pkg::sample_vec_t  in_samples,
    output logic                      stage_valid,
    output outlier_pkg::sample_vec_t  stage_samples,
    output outlier_pkg::code_vec_t    stage_codes
);

    // code of each incoming channel, before the register
    outlier_pkg::code_vec_t codes_next;

    always_comb begin
        for (int c = 0; c < outlier_pkg::CHANNELS; c++) begin
            // bits just below the sign
            // flipped for negative samples, so -1 and 0 both land on code 0
            codes_next[c] = in_samples[c][outlier_pkg::SAMPLE_BITS-2 -: outlier_pkg::CODE_BITS]
                ^ {outlier_pkg::CODE_BITS{in_samples[c][outlier_pkg::SAMPLE_BITS-1]}};
        end
    end

    // strobe follows input by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
            stage_codes <= '0;
        end else begin
            stage_valid <= in_valid;
            if (in_valid) begin
                stage_codes <= codes_next;
            end
        end
    end

    // samples ride along with their codes
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage_samples <= in_samples;
        end
    end

endmodule

`default_nettype wire

// File: design/outlier_selector.sv
`timescale 1ns/1ns
`default_nettype none

module outlier_selector (
    input  logic                        clk,
    input  logic                        reset,
    input  outlier_pkg::code_vec_t      stage_codes,
    input  outlier_pkg::split_cfg_t     cfg,
    output outlier_pkg::channel_mask_t  pick_mask
);

    outlier_pkg::channel_mask_t flags;
    // flags not yet taken by an earlier round
    outlier_pkg::channel_mask_t remaining;
    outlier_pkg::channel_mask_t lowest;
    // flagged channels that lost out to the limit
    outlier_pkg::channel_mask_t unpicked;
    outlier_pkg::channel_mask_t unpicked_low;

    // threshold compare per channel
    always_comb begin
        for (int c = 0; c < outlier_pkg::CHANNELS; c++) begin
            flags[c] = (stage_codes[c] >= cfg.threshold);
        end
    end

    // lowest set bit isolation, one round per possible outlier
    always_comb begin
        remaining = flags;
        lowest    = '0;
        pick_mask = '0;
        for (int r = 0; r < outlier_pkg::MAX_OUTLIERS; r++) begin
            lowest    = remaining & ~(remaining - 1'b1);
            remaining = remaining & ~lowest;
            // rounds past the limit are computed but dropped
            if (r < int'(cfg.outlier_limit)) begin
                pick_mask = pick_mask | lowest;
            end
        end
    end

    assign unpicked     = flags & ~pick_mask;
    assign unpicked_low = unpicked & ~(unpicked - 1'b1);

    // only flagged channels may be picked
    a_mask_in_flags: assert property (@(posedge clk) disable iff (reset)
        (pick_mask & ~flags) == '0);

    // never more picks than the limit allows
    a_mask_limit: assert property (@(posedge clk) disable iff (reset)
        $countones(pick_mask) <= int'(cfg.outlier_limit));

    // a skipped flag sits above all picks, nothing picked at or past it
    a_lowest_first: assert property (@(posedge clk) disable iff (reset)
        (pick_mask & ~(unpicked_low - 1'b1)) == '0);

endmodule

`default_nettype wire

// File: design/channel_splitter.sv
`timescale 1ns/1ns
`default_nettype none

module channel_splitter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stage_valid,
    input  outlier_pkg::sample_vec_t    stage_samples,
    input  outlier_pkg::channel_mask_t  pick_mask,
    output logic                        out_valid,
    output outlier_pkg::split_result_t  out_result
);

    outlier_pkg::split_result_t result_next;

    // each channel goes to one side and zero to the other
    always_comb begin
        result_next.mask = pick_mask;
        for (int c = 0; c < outlier_pkg::CHANNELS; c++) begin
            if (pick_mask[c]) begin
                result_next.outliers[c] = stage_samples[c];
                result_next.inliers[c]  = '0;
            end else begin
                result_next.outliers[c] = '0;
                result_next.inliers[c]  = stage_samples[c];
            end
        end
    end

    // result holds between strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_result <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                out_result <= result_next;
            end
        end
    end

    // staged sample and mask come out one cycle later
    // chosen side carries the sample and the other side reads zero
    for (genvar c = 0; c < outlier_pkg::CHANNELS; c++) begin : g_side_check
        a_side_routing: assert property (@(posedge clk) disable iff (reset)
            out_valid |-> (out_result.mask[c] == $past(pick_mask[c]))
                && (out_result.mask[c]
                    ? (out_result.outliers[c] == $past(stage_samples[c])
                       && out_result.inliers[c] == '0)
                    : (out_result.inliers[c] == $past(stage_samples[c])
                       && out_result.outliers[c] == '0)));
    end

endmodule

`default_nettype wire

// File: design/split_config_regs.sv
`timescale 1ns/1ns
`default_nettype none

module split_config_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cfg_write,
    input  logic                     cfg_addr,
    input  logic [7:0]               cfg_wdata,
    output logic [7:0]               cfg_rdata,
    output outlier_pkg::split_cfg_t  cfg
);

    // write decode, only the low bits of wdata are kept
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.threshold     <= outlier_pkg::THRESHOLD_RESET;
            cfg.outlier_limit <= outlier_pkg::LIMIT_RESET;
        end else if (cfg_write) begin
            case (cfg_addr)
                outlier_pkg::CFG_ADDR_THRESHOLD: begin
                    cfg.threshold <= cfg_wdata[outlier_pkg::CODE_BITS-1:0];
                end
                outlier_pkg::CFG_ADDR_LIMIT: begin
                    cfg.outlier_limit <= cfg_wdata[outlier_pkg::LIMIT_BITS-1:0];
                end
                default: begin
                    // nothing mapped here
                end
            endcase
        end
    end

    // readback mux, zero extended to the port width
    always_comb begin
        case (cfg_addr)
            outlier_pkg::CFG_ADDR_THRESHOLD: begin
                cfg_rdata = {{(8-outlier_pkg::CODE_BITS){1'b0}}, cfg.threshold};
            end
            outlier_pkg::CFG_ADDR_LIMIT: begin
                cfg_rdata = {{(8-outlier_pkg::LIMIT_BITS){1'b0}}, cfg.outlier_limit};
            end
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/outlier_split_top.sv
`timescale 1ns/1ns
`default_nettype none

module outlier_split_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  outlier_pkg::sample_vec_t    in_samples,
    output logic                        out_valid,
    output outlier_pkg::split_result_t  out_result,
    input  logic                        cfg_write,
    input  logic                        cfg_addr,
    input  logic [7:0]                  cfg_wdata,
    output logic [7:0]                  cfg_rdata
);

    // register block to selector
    outlier_pkg::split_cfg_t    cfg;

    // quantizer stage outputs
    logic                       stage_valid;
    outlier_pkg::sample_vec_t   stage_samples;
    outlier_pkg::code_vec_t     stage_codes;

    // selector output, same cycle as the stage
    outlier_pkg::channel_mask_t pick_mask;

    split_config_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

    // cycle 1, samples and codes
    magnitude_quantizer u_quant (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_samples    (in_samples),
        .stage_valid   (stage_valid),
        .stage_samples (stage_samples),
        .stage_codes   (stage_codes)
    );

    // combinational, clk only feeds its checks
    outlier_selector u_select (
        .clk         (clk),
        .reset       (reset),
        .stage_codes (stage_codes),
        .cfg         (cfg),
        .pick_mask   (pick_mask)
    );

    // cycle 2, the split result
    channel_splitter u_split (
        .clk           (clk),
        .reset         (reset),
        .stage_valid   (stage_valid),
        .stage_samples (stage_samples),
        .pick_mask     (pick_mask),
        .out_valid     (out_valid),
        .out_result    (out_result)
    );

endmodule

`default_nettype wire

// File: testbench/outlier_split_checker.sv
`timescale 1ns/1ns
`default_nettype none

module outlier_split_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  outlier_pkg::sample_vec_t    in_samples,
    input  logic                        out_valid,
    input  outlier_pkg::split_result_t  out_result,
    input  logic                        cfg_write,
    input  logic                        cfg_addr,
    input  logic [7:0]                  cfg_wdata,
    output int                          pending,
    output int                          total_errors
);

    // expected results in entry order, and the cycle each one is due
    outlier_pkg::split_result_t exp_q[$];
    int                         due_q[$];
    // mirror of the register block, kept from the write port
    outlier_pkg::split_cfg_t    cfg_model;
    int                         cycle;
    string                      test_name;
    int                         test_checks;
    int                         test_errors;
    int                         total_checks;
    int                         test_count;

    initial begin
        pending      = 0;
        total_errors = 0;
        cycle        = 0;
        test_name    = "idle";
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        test_count   = 0;
    end

    // expected split: code, threshold, lowest channels first up to the limit
    function automatic outlier_pkg::split_result_t expected_split(
        input outlier_pkg::sample_vec_t samples,
        input logic [2:0]               threshold,
        input logic [1:0]               limit
    );
        outlier_pkg::split_result_t res;
        logic [2:0]                 code;
        int                         picked;
        res    = '0;
        picked = 0;
        for (int c = 0; c < 8; c++) begin
            // three bits under the sign, flipped for negatives
            code = samples[c][14:12];
            if (samples[c][15]) begin
                code = ~code;
            end
            if (code >= threshold && picked < int'(limit)) begin
                res.mask[c]     = 1'b1;
                res.outliers[c] = samples[c];
                picked++;
            end else begin
                res.inliers[c] = samples[c];
            end
        end
        return res;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        test_count++;
        total_checks += test_checks;
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic report_totals();
        $display("totals: %0d tests, %0d checks, %0d errors",
                 test_count, total_checks, total_errors);
    endtask

    // value compare, also used for register reads
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        if (expected !== actual) begin
            test_errors++;
            total_errors++;
            $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        test_errors++;
        total_errors++;
        $display("error in %s: %s", test_name, msg);
    endtask

    always @(posedge clk) begin : compare
        outlier_pkg::split_result_t expected;
        int                         due;
        if (reset) begin
            cfg_model.threshold     = outlier_pkg::THRESHOLD_RESET;
            cfg_model.outlier_limit = outlier_pkg::LIMIT_RESET;
            exp_q.delete();
            due_q.delete();
        end else begin
            cycle++;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    report_problem("out_valid came with no vector in flight");
                end else begin
                    expected = exp_q.pop_front();
                    due      = due_q.pop_front();
                    if (due != cycle) begin
                        report_problem("result came out at the wrong cycle");
                    end
                    test_checks++;
                    if (out_result !== expected) begin
                        test_errors++;
                        total_errors++;
                        $display("FAIL %s result expected %h actual %h",
                                 test_name, expected, out_result);
                    end
                end
            end
            // anything past its cycle never showed up
            while (due_q.size() > 0 && due_q[0] < cycle) begin
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                report_problem("an expected out_valid did not arrive");
            end
            // a write here already steers the vector captured now
            if (cfg_write) begin
                if (cfg_addr == outlier_pkg::CFG_ADDR_THRESHOLD) begin
                    cfg_model.threshold = cfg_wdata[2:0];
                end else begin
                    cfg_model.outlier_limit = cfg_wdata[1:0];
                end
            end
            if (in_valid) begin
                exp_q.push_back(expected_split(in_samples, cfg_model.threshold,
                                               cfg_model.outlier_limit));
                due_q.push_back(cycle + 2);
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// File: testbench/outlier_split_tb.sv
`timescale 1ns/1ns
`default_nettype none

module outlier_split_tb;

    logic                       clk;
    logic                       reset;
    logic                       in_valid;
    outlier_pkg::sample_vec_t   in_samples;
    logic                       out_valid;
    outlier_pkg::split_result_t out_result;
    logic                       cfg_write;
    logic                       cfg_addr;
    logic [7:0]                 cfg_wdata;
    logic [7:0]                 cfg_rdata;
    // checker status
    int                         pending;
    int                         total_errors;

    outlier_split_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_samples (in_samples),
        .out_valid  (out_valid),
        .out_result (out_result),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    outlier_split_checker checker0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_samples   (in_samples),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .pending      (pending),
        .total_errors (total_errors)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic send_vector(input outlier_pkg::sample_vec_t v);
        @(posedge clk);
        in_valid   <= 1'b1;
        in_samples <= v;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // stop the stream, then wait until every result was seen
    task automatic drain(input int limit);
        int waited;
        idle_cycle();
        @(negedge clk);
        waited = 0;
        while (pending != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results still missing after %0d cycles", pending, limit);
            $display("Checks failed");
            $finish;
        end
    endtask

    task automatic write_cfg(input logic addr, input logic [7:0] data);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
    endtask

    // readback is combinational, sampled mid cycle
    task automatic read_cfg(input logic addr, input string what, input logic [7:0] expected);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        checker0.check_value(what, expected, cfg_rdata);
    endtask

    initial begin
        outlier_pkg::sample_vec_t v;
        int                       burst_len;
        void'($urandom(32'hb65b));
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_samples = '0;
        cfg_write  = 1'b0;
        cfg_addr   = 1'b0;
        cfg_wdata  = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // quiet output, register defaults
        checker0.start_test("reset_state");
        repeat (4) begin
            @(negedge clk);
            checker0.check_value("out_valid", 0, out_valid);
        end
        read_cfg(1'b0, "threshold", 8'd6);
        read_cfg(1'b1, "limit", 8'd2);
        checker0.end_test();

        // codes 5 and 6 from both signs, default threshold
        checker0.start_test("sign_rule");
        send_vector({16'h7FFF, 16'h8000, 16'h7000, 16'hAFFF,
                     16'h9FFF, 16'hA000, 16'h6000, 16'h5FFF});
        send_vector({16'h6FFF, 16'h8FFF, 16'h1000, 16'h8000,
                     16'h1000, 16'h9000, 16'h0FFF, 16'hFFFF});
        send_vector({16'h9000, 16'h6000, 16'hA000, 16'h5FFF,
                     16'hB000, 16'h4FFF, 16'hFFFF, 16'h0000});
        send_vector({16'h8001, 16'h7001, 16'hAFFF, 16'h5000,
                     16'h8000, 16'hFFFF, 16'hA001, 16'h5FFF});
        drain(20);
        checker0.end_test();

        // threshold decides the flags
        checker0.start_test("threshold");
        write_cfg(1'b1, 8'd3);
        write_cfg(1'b0, 8'd0);
        read_cfg(1'b0, "threshold", 8'd0);
        send_vector({16'h0001, 16'hFFFF, 16'h0000, 16'hF000,
                     16'h0FFF, 16'h8000, 16'h7FFF, 16'hFFFE});
        drain(20);
        write_cfg(1'b0, 8'hF7);
        read_cfg(1'b0, "threshold", 8'd7);
        send_vector({16'h6FFF, 16'h8000, 16'h7000, 16'h9000,
                     16'h8FFF, 16'h0000, 16'h6000, 16'h7FFF});
        drain(20);
        write_cfg(1'b0, 8'd3);
        send_vector({16'h2FFF, 16'hC000, 16'hCFFF, 16'h3000,
                     16'hD000, 16'h2000, 16'hB000, 16'h1FFF});
        drain(20);
        checker0.end_test();

        // limits 0 to 3, flags on channels 1 2 4 6 7
        checker0.start_test("limit");
        write_cfg(1'b0, 8'd4);
        for (int l = 0; l < 4; l++) begin
            write_cfg(1'b1, 8'(l));
            read_cfg(1'b1, "limit", 8'(l));
            send_vector({16'h4000, 16'hB000, 16'h3FFF, 16'h7FFF,
                         16'hC000, 16'hBFFF, 16'h5000, 16'h1234});
            drain(20);
        end
        checker0.end_test();

        // random bursts, each under a fresh config
        checker0.start_test("random_stream");
        repeat (12) begin
            write_cfg(1'b0, 8'($urandom_range(255)));
            write_cfg(1'b1, 8'($urandom_range(255)));
            burst_len = $urandom_range(16, 1);
            repeat (burst_len) begin
                if ($urandom_range(3) == 0) begin
                    idle_cycle();
                end
                for (int c = 0; c < outlier_pkg::CHANNELS; c++) begin
                    v[c] = 16'($urandom);
                end
                send_vector(v);
            end
            drain(20);
        end
        checker0.end_test();

        checker0.report_totals();
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
design/outlier_pkg.sv
design/magnitude_quantizer.sv
design/outlier_selector.sv
design/channel_splitter.sv
design/split_config_regs.sv
design/outlier_split_top.sv
testbench/outlier_split_checker.sv
testbench/outlier_split_tb.sv

// File: Bender.yml
package:
  name: outlier_split

sources:
  # package first, then the RTL in dependency order
  - design/outlier_pkg.sv
  - design/magnitude_quantizer.sv
  - design/outlier_selector.sv
  - design/channel_splitter.sv
  - design/split_config_regs.sv
  - design/outlier_split_top.sv

  # testbench, top module outlier_split_tb
  - target: test
    files:
      - testbench/outlier_split_checker.sv
      - testbench/outlier_split_tb.sv
